// ==== hw/buffer_regs.sv ====
`timescale 1ns/1ns

module buffer_regs (
    input  logic                sim_clk,
    input  logic                rst_n,
    pio_cmd_if.unit             cmd,
    output lvda_pkg::pio_word_t brd,
    output logic                rvalid,
    output lvda_pkg::pio_word_t rdata
);

    logic wr_hit;
    logic rd_hit;

    assign wr_hit = cmd.cmd_valid && (cmd.cmd_op == lvda_pkg::OP_WR_BUFFER);
    assign rd_hit = cmd.cmd_valid && (cmd.cmd_op == lvda_pkg::OP_RD_BUFFER);

    // BRD lines drive straight off this register
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            brd    <= '0;
            rvalid <= 1'b0;
        end else begin
            rvalid <= rd_hit;
            if (wr_hit) begin
                brd <= cmd.cmd_data;
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rd_hit) begin
            rdata <= brd;  // Readback of what the processor last wrote
        end
    end

endmodule

// ==== hw/discrete_sampler.sv ====
`timescale 1ns/1ns

module discrete_sampler (
    input  logic                sim_clk,
    input  logic                rst_n,
    pio_cmd_if.unit             cmd,
    input  lvda_pkg::din_word_t din,
    output logic                rvalid,
    output lvda_pkg::pio_word_t rdata
);

    lvda_pkg::din_word_t snapshot;
    logic                changed;
    logic                rd_hit;

    assign rd_hit = cmd.cmd_valid && (cmd.cmd_op == lvda_pkg::OP_RD_DISCRETE);

    // Snapshot starts at zero to match the filter outputs after reset
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid   <= 1'b0;
            snapshot <= '0;
            changed  <= 1'b0;
        end else begin
            rvalid <= rd_hit;
            if (rd_hit) begin
                snapshot <= din;
                changed  <= 1'b0;
            end else if (din != snapshot) begin
                changed <= 1'b1;  // Sticky until the next discrete read
            end
        end
    end

    // Bit 24 flags a change since the last discrete read
    always_ff @(posedge sim_clk) begin
        if (rd_hit) begin
            rdata <= {1'b0, changed | (din != snapshot), din};
        end
    end

endmodule

// ==== hw/interrupt_proc.sv ====
`timescale 1ns/1ns
`include "lvda_settings.svh"

module interrupt_proc (
    input  logic                 sim_clk,
    input  logic                 rst_n,
    pio_cmd_if.unit              cmd,
    input  lvda_pkg::intr_word_t intr,
    output logic                 rvalid,
    output lvda_pkg::pio_word_t  rdata,
    output logic                 intc
);

    lvda_pkg::intr_word_t intr_q;
    lvda_pkg::intr_word_t rise;
    lvda_pkg::intr_word_t pending;
    lvda_pkg::intr_word_t mask;
    lvda_pkg::intr_word_t clr;
    logic                 rd_hit;
    logic                 mask_hit;

    assign rd_hit   = cmd.cmd_valid && (cmd.cmd_op == lvda_pkg::OP_RD_INTR);
    assign mask_hit = cmd.cmd_valid && (cmd.cmd_op == lvda_pkg::OP_WR_MASK);

    assign rise = intr & ~intr_q;

    // Write-one-to-clear bits taken from the command word
    always_comb begin
        clr = '0;
        if (cmd.cmd_valid && (cmd.cmd_op == lvda_pkg::OP_CLR_INTR)) begin
            clr = cmd.cmd_data[`LVDA_INTR_N-1:0];
        end
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_q  <= '0;
            pending <= '0;
            mask    <= '0;
            intc    <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            intr_q  <= intr;
            pending <= (pending & ~clr) | rise;  // A new edge beats a clear
            intc    <= |(pending & mask);
            rvalid  <= rd_hit;
            if (mask_hit) begin
                mask <= cmd.cmd_data[`LVDA_INTR_N-1:0];
            end
        end
    end

    // Status word is pending in the low bits and the mask above it
    always_ff @(posedge sim_clk) begin
        if (rd_hit) begin
            rdata <= {{(`LVDA_DATA_W - 2 * `LVDA_INTR_N){1'b0}}, mask, pending};
        end
    end

    // The computer flag stays low while the mask sits at zero
    assert property (@(posedge sim_clk) disable iff (!rst_n)
        ((mask == '0) && $stable(mask)) |-> !intc);

endmodule

// ==== hw/lvda_core.sv ====
`timescale 1ns/1ns
`include "lvda_settings.svh"

module lvda_core (
    input  logic                    sim_clk,
    input  logic                    rst_n,
    input  logic                    pio_strobe,
    input  logic                    pio_write,
    input  logic [`LVDA_ADDR_W-1:0] pio_addr,
    input  lvda_pkg::pio_word_t     pio_wdata,
    input  lvda_pkg::din_word_t     din_raw,
    input  lvda_pkg::intr_word_t    intr_raw,
    output logic                    rd_valid,
    output lvda_pkg::pio_word_t     rd_data,
    output lvda_pkg::pio_word_t     brd,
    output logic                    intc
);

    lvda_pkg::din_word_t  din_clean;
    lvda_pkg::intr_word_t intr_clean;

    logic                disc_rvalid;
    lvda_pkg::pio_word_t disc_rdata;
    logic                intr_rvalid;
    lvda_pkg::pio_word_t intr_rdata;
    logic                buf_rvalid;
    lvda_pkg::pio_word_t buf_rdata;

    pio_cmd_if cmd_bus ();

    // Transient protection on the discrete and interrupt lines
    transient_filter #(
        .WIDTH(`LVDA_DIN_N)
    ) u_din_filter (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .raw    (din_raw),
        .clean  (din_clean)
    );

    transient_filter #(
        .WIDTH(`LVDA_INTR_N)
    ) u_intr_filter (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .raw    (intr_raw),
        .clean  (intr_clean)
    );

    pio_controller u_pio_controller (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .pio_strobe (pio_strobe),
        .pio_write  (pio_write),
        .pio_addr   (pio_addr),
        .pio_wdata  (pio_wdata),
        .cmd        (cmd_bus.ctrl),
        .disc_rvalid(disc_rvalid),
        .disc_rdata (disc_rdata),
        .intr_rvalid(intr_rvalid),
        .intr_rdata (intr_rdata),
        .buf_rvalid (buf_rvalid),
        .buf_rdata  (buf_rdata),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    discrete_sampler u_discrete_sampler (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .cmd    (cmd_bus.unit),
        .din    (din_clean),
        .rvalid (disc_rvalid),
        .rdata  (disc_rdata)
    );

    interrupt_proc u_interrupt_proc (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .cmd    (cmd_bus.unit),
        .intr   (intr_clean),
        .rvalid (intr_rvalid),
        .rdata  (intr_rdata),
        .intc   (intc)
    );

    buffer_regs u_buffer_regs (
        .sim_clk(sim_clk),
        .rst_n  (rst_n),
        .cmd    (cmd_bus.unit),
        .brd    (brd),
        .rvalid (buf_rvalid),
        .rdata  (buf_rdata)
    );

endmodule

// ==== hw/lvda_pkg.sv ====
`include "lvda_settings.svh"

package lvda_pkg;

    // Operation decoded from a PIO address and direction
    typedef enum logic [2:0] {
        OP_NONE,
        OP_RD_DISCRETE,
        OP_RD_INTR,
        OP_RD_BUFFER,
        OP_WR_BUFFER,
        OP_WR_MASK,
        OP_CLR_INTR
    } pio_op_e;

    typedef logic [`LVDA_DATA_W-1:0] pio_word_t;  // PIO data and BRD word

    typedef logic [`LVDA_DIN_N-1:0] din_word_t;

    typedef logic [`LVDA_INTR_N-1:0] intr_word_t;

endpackage

// ==== hw/lvda_settings.svh ====
`ifndef LVDA_SETTINGS_SVH
`define LVDA_SETTINGS_SVH

// Bus and word widths
`define LVDA_ADDR_W 9
`define LVDA_DATA_W 26

// Line counts of the two filtered groups
`define LVDA_DIN_N  24
`define LVDA_INTR_N 7

// Cycles a synchronized level must hold before the filter takes it
`define LVDA_FILTER_LEN 4

// Read side of the PIO address map
`define LVDA_ADR_DISCRETE  9'h010
`define LVDA_ADR_INTR_STAT 9'h011
`define LVDA_ADR_BUFFER    9'h012

// Write side of the PIO address map
`define LVDA_ADR_BUFFER_WR 9'h020
`define LVDA_ADR_INTR_MASK 9'h021
`define LVDA_ADR_INTR_CLR  9'h022

`endif

// ==== hw/pio_cmd_if.sv ====
`timescale 1ns/1ns

interface pio_cmd_if;

    logic                cmd_valid;  // One cycle per accepted command
    lvda_pkg::pio_op_e   cmd_op;
    lvda_pkg::pio_word_t cmd_data;

    modport ctrl (
        output cmd_valid,
        output cmd_op,
        output cmd_data
    );

    modport unit (
        input cmd_valid,
        input cmd_op,
        input cmd_data
    );

endinterface

// ==== hw/pio_controller.sv ====
`timescale 1ns/1ns
`include "lvda_settings.svh"

module pio_controller (
    input  logic                    sim_clk,
    input  logic                    rst_n,
    input  logic                    pio_strobe,
    input  logic                    pio_write,
    input  logic [`LVDA_ADDR_W-1:0] pio_addr,
    input  lvda_pkg::pio_word_t     pio_wdata,
    pio_cmd_if.ctrl                 cmd,
    input  logic                    disc_rvalid,
    input  lvda_pkg::pio_word_t     disc_rdata,
    input  logic                    intr_rvalid,
    input  lvda_pkg::pio_word_t     intr_rdata,
    input  logic                    buf_rvalid,
    input  lvda_pkg::pio_word_t     buf_rdata,
    output logic                    rd_valid,
    output lvda_pkg::pio_word_t     rd_data
);

    logic                    strb_q;
    logic                    write_q;
    logic [`LVDA_ADDR_W-1:0] addr_q;
    lvda_pkg::pio_word_t     wdata_q;
    lvda_pkg::pio_op_e       op_dec;

    // First stage holds the raw PIO request
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            strb_q <= 1'b0;
        end else begin
            strb_q <= pio_strobe;
        end
    end

    always_ff @(posedge sim_clk) begin
        write_q <= pio_write;
        addr_q  <= pio_addr;
        wdata_q <= pio_wdata;
    end

    // Address map decode, wrong direction falls to OP_NONE
    always_comb begin
        op_dec = lvda_pkg::OP_NONE;
        if (strb_q && !write_q) begin
            case (addr_q)
                `LVDA_ADR_DISCRETE:  op_dec = lvda_pkg::OP_RD_DISCRETE;
                `LVDA_ADR_INTR_STAT: op_dec = lvda_pkg::OP_RD_INTR;
                `LVDA_ADR_BUFFER:    op_dec = lvda_pkg::OP_RD_BUFFER;
                default:             op_dec = lvda_pkg::OP_NONE;
            endcase
        end else if (strb_q) begin
            case (addr_q)
                `LVDA_ADR_BUFFER_WR: op_dec = lvda_pkg::OP_WR_BUFFER;
                `LVDA_ADR_INTR_MASK: op_dec = lvda_pkg::OP_WR_MASK;
                `LVDA_ADR_INTR_CLR:  op_dec = lvda_pkg::OP_CLR_INTR;
                default:             op_dec = lvda_pkg::OP_NONE;
            endcase
        end
    end

    // Second stage issues the decoded command to the units
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.cmd_valid <= 1'b0;
            cmd.cmd_op    <= lvda_pkg::OP_NONE;
        end else begin
            cmd.cmd_valid <= (op_dec != lvda_pkg::OP_NONE);
            cmd.cmd_op    <= op_dec;
        end
    end

    always_ff @(posedge sim_clk) begin
        cmd.cmd_data <= wdata_q;
    end

    // Reply stage merges whichever unit answered
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= disc_rvalid | intr_rvalid | buf_rvalid;
        end
    end

    always_ff @(posedge sim_clk) begin
        rd_data <= ({`LVDA_DATA_W{disc_rvalid}} & disc_rdata)
                 | ({`LVDA_DATA_W{intr_rvalid}} & intr_rdata)
                 | ({`LVDA_DATA_W{buf_rvalid}}  & buf_rdata);
    end

    // Units must never answer together or the merge would corrupt the reply
    assert property (@(posedge sim_clk) disable iff (!rst_n)
        $onehot0({disc_rvalid, intr_rvalid, buf_rvalid}));

endmodule

// ==== hw/transient_filter.sv ====
`timescale 1ns/1ns
`include "lvda_settings.svh"

module transient_filter #(
    parameter int WIDTH = 8
) (
    input  logic             sim_clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] clean
);

    localparam int CNT_W = $clog2(`LVDA_FILTER_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LVDA_FILTER_LEN - 1);

    logic [WIDTH-1:0] sync_a;
    logic [WIDTH-1:0] sync_b;
    logic [CNT_W-1:0] cnt [WIDTH];

    // Two-flop synchronizer on every raw line
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a <= raw;
            sync_b <= sync_a;
        end
    end

    // A line's clean level moves only after the new level has held long enough
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            clean <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_b[i] != clean[i]) begin
                    if (cnt[i] == CNT_LAST) begin
                        clean[i] <= sync_b[i];  // Level held for the full window
                        cnt[i]   <= '0;
                    end else begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end else begin
                    cnt[i] <= '0;  // Glitch ended early so start over
                end
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f src.f --top-module lvda_tb -Mdir obj_dir -o lvda_sim

./obj_dir/lvda_sim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== src.f ====
+incdir+hw
hw/lvda_pkg.sv
hw/pio_cmd_if.sv
hw/transient_filter.sv
hw/pio_controller.sv
hw/discrete_sampler.sv
hw/interrupt_proc.sv
hw/buffer_regs.sv
hw/lvda_core.sv
verif/lvda_tb.sv

// ==== verif/lvda_tb.sv ====
`timescale 1ns/1ns
`include "lvda_settings.svh"

module lvda_tb;

    logic                    sim_clk = 1'b0;
    logic                    rst_n;
    logic                    pio_strobe;
    logic                    pio_write;
    logic [`LVDA_ADDR_W-1:0] pio_addr;
    lvda_pkg::pio_word_t     pio_wdata;
    lvda_pkg::din_word_t     din_raw;
    lvda_pkg::intr_word_t    intr_raw;
    logic                    rd_valid;
    lvda_pkg::pio_word_t     rd_data;
    lvda_pkg::pio_word_t     brd;
    logic                    intc;

    int                  cyc = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  run_cycles = 0;
    integer              seed = 32'hffb86aaf;
    int                  due_q[$];  // Cycle in which each read reply must show up
    lvda_pkg::pio_word_t exp_q[$];

    lvda_core UUT (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .pio_strobe(pio_strobe),
        .pio_write (pio_write),
        .pio_addr  (pio_addr),
        .pio_wdata (pio_wdata),
        .din_raw   (din_raw),
        .intr_raw  (intr_raw),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .brd       (brd),
        .intc      (intc)
    );

    always #4 sim_clk = ~sim_clk;

    always @(posedge sim_clk) begin
        cyc <= cyc + 1;
    end

    // Replies are sampled mid-cycle, well away from the driving edge
    always @(negedge sim_clk) begin
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            checks++;
            if (rd_valid !== 1'b1) begin
                $display("No rd_valid in cycle %0d, 3 cycles after a read strobe", cyc);
                errors++;
            end else if (rd_data !== exp_q[0]) begin
                $display("FAILED rd_data: expected %h, got %h", exp_q[0], rd_data);
                errors++;
            end
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end else if (rst_n && rd_valid !== 1'b0) begin
            $display("rd_valid came in cycle %0d with no read due", cyc);
            errors++;
        end
    end

    task automatic next_cycle();
        @(posedge sim_clk);
        #1;
        pio_strobe = 1'b0;
    endtask

    task automatic send(input logic wr, input logic [`LVDA_ADDR_W-1:0] adr,
                        input lvda_pkg::pio_word_t data, input logic want_reply);
        next_cycle();
        pio_strobe = 1'b1;
        pio_write  = wr;
        pio_addr   = adr;
        pio_wdata  = wr ? data : '0;
        if (want_reply) begin
            due_q.push_back(cyc + 4);  // Taken at the next edge, answered 3 edges later
            exp_q.push_back(data);
        end
    endtask

    initial begin
        int                  fd;
        int                  n;
        int                  lines;
        logic [63:0]         kw;
        logic [31:0]         a1;
        logic [31:0]         a2;
        logic [31:0]         rnd;
        logic [8*160-1:0]    line;
        lvda_pkg::pio_word_t word;
        lvda_pkg::din_word_t prev;

        rst_n      = 1'b0;
        pio_strobe = 1'b0;
        pio_write  = 1'b0;
        pio_addr   = '0;
        pio_wdata  = '0;
        din_raw    = '0;
        intr_raw   = '0;
        word       = '0;
        lines      = 0;
        fd = $fopen("verif/lvda_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file verif/lvda_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                lines++;
            end
            $fclose(fd);
            run_cycles = lines * 64;
            fd = $fopen("verif/lvda_tests.txt", "r");
        end
        repeat (3) @(posedge sim_clk);
        #1;
        rst_n = 1'b1;
        while (fd != 0 && $fscanf(fd, "%s", kw) == 1) begin
            a1 = '0;
            a2 = '0;
            case (kw)
                64'("#"): n = $fgets(line, fd);
                64'("wr"): begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    send(1'b1, a1[`LVDA_ADDR_W-1:0], a2[`LVDA_DATA_W-1:0], 1'b0);
                end
                64'("rd"): begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    send(1'b0, a1[`LVDA_ADDR_W-1:0], a2[`LVDA_DATA_W-1:0], 1'b1);
                end
                64'("rdx"): begin
                    n = $fscanf(fd, "%h", a1);
                    send(1'b0, a1[`LVDA_ADDR_W-1:0], '0, 1'b0);
                end
                64'("din"): begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    din_raw = a1[`LVDA_DIN_N-1:0];
                    repeat (a2) next_cycle();
                end
                64'("intr"): begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    intr_raw = a1[`LVDA_INTR_N-1:0];
                    repeat (a2) next_cycle();
                end
                64'("glitch"): begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    prev    = din_raw;
                    din_raw = a1[`LVDA_DIN_N-1:0];
                    repeat (a2) next_cycle();
                    din_raw = prev;
                end
                64'("idle"): begin
                    n = $fscanf(fd, "%h", a1);
                    repeat (a1) next_cycle();
                end
                64'("intc"): begin
                    n = $fscanf(fd, "%h", a1);
                    checks++;
                    if (intc !== a1[0]) begin
                        $display("FAILED intc: expected %h, got %h", a1[0], intc);
                        errors++;
                    end
                end
                64'("brd"): begin
                    n = $fscanf(fd, "%h", a1);
                    checks++;
                    if (brd !== a1[`LVDA_DATA_W-1:0]) begin
                        $display("FAILED brd: expected %h, got %h", a1[`LVDA_DATA_W-1:0], brd);
                        errors++;
                    end
                end
                64'("rndbuf"): begin
                    n = $fscanf(fd, "%h", a1);
                    repeat (a1) begin
                        rnd  = $random(seed);
                        word = rnd[`LVDA_DATA_W-1:0];  // BRD holds the low 26 bits written
                        send(1'b1, `LVDA_ADR_BUFFER_WR, word, 1'b0);
                        send(1'b0, `LVDA_ADR_BUFFER, word, 1'b1);
                    end
                    repeat (4) next_cycle();
                    checks++;
                    if (brd !== word) begin
                        $display("FAILED brd: expected %h, got %h", word, brd);
                        errors++;
                    end
                end
                default: begin
                    $display("Unknown action %0s in the test file", kw);
                    errors++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (8) next_cycle();
        if (due_q.size() != 0) begin
            $display("%0d read replies never arrived", due_q.size());
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Budget of 64 cycles for every line of the test file
    initial begin
        wait (run_cycles > 0);
        #(run_cycles * 8);
        $display("Timeout after %0d cycles, the tests did not finish", run_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verif/lvda_tests.txt ====
# action arg1 arg2, every number in hex (hold 14 is 20 cycles)
# wr adr data | rd adr expect | rdx adr | din, intr, glitch val cycles | idle n | intc, brd expect | rndbuf n
idle a
brd 0
rd 012 0
wr 020 2abcdef
idle 4
brd 2abcdef
wr 020 1234567
rd 012 1234567
rd 012 1234567
rd 011 0
rd 010 0
din a5c3e1 14
rd 010 1a5c3e1
rd 010 a5c3e1
glitch ffffff 3
din a5c3e1 14
rd 010 a5c3e1
din 00ff00 14
rd 010 100ff00
intr 04 14
rd 011 4
intc 0
wr 021 04
idle 6
intc 1
intr 0d 14
rd 011 20d
wr 022 05
idle 6
rd 011 208
intc 0
wr 021 0c
idle 6
intc 1
rdx 000
rdx 022
rdx 1ff
wr 011 3ffffff
wr 012 3ffffff
wr 055 3ffffff
idle 6
brd 1234567
intc 1
rd 011 608
wr 022 08
idle 6
intc 0
rndbuf 8
